/* design/row_filter_pkg.sv */
`default_nettype none

package row_filter_pkg;

    localparam int ROW_W = 20;
    localparam int CSR_W = 64;
    localparam int ID_W  = 8;

    typedef enum logic [2:0] {
        mode_idle,
        mode_insert,
        mode_clear,
        mode_lookup,
        mode_code_load,
        mode_code_match
    } filter_mode_e;

    // command words, one per mode
    localparam logic [CSR_W-1:0] CMD_IDLE       = 64'hDEADBEEFDEADBEEF;
    localparam logic [CSR_W-1:0] CMD_INSERT     = 64'hACE0DEADACE0BEEF;
    localparam logic [CSR_W-1:0] CMD_LOOKUP     = 64'hDEADACE0BEEF0ECA;
    localparam logic [CSR_W-1:0] CMD_CODE_LOAD  = 64'h0000DEADACE0BEEF;
    localparam logic [CSR_W-1:0] CMD_CODE_MATCH = 64'h0000ACE0BEEFACE0;
    localparam logic [CSR_W-1:0] CMD_CLEAR      = 64'hBEEFDEAD0ACEBEEF;

    // framing tags of a code-load data word
    localparam logic [11:0] CODE_TAG_HI = 12'hECA;
    localparam logic [11:0] CODE_TAG_LO = 12'hCAE;

    typedef struct packed {
        logic [11:0]      tag_hi;
        logic [ROW_W-1:0] mask;
        logic [ROW_W-1:0] code;
        logic [11:0]      tag_lo;
    } code_load_s;

    // row bits sit where the controller's address map puts them
    typedef struct packed {
        logic [29:0] pad_hi;
        logic [17:0] row_hi;
        logic [6:0]  pad_mid;
        logic [1:0]  row_lo;
        logic [6:0]  pad_lo;
    } row_entry_s;

    typedef union packed {
        logic [CSR_W-1:0] raw;
        code_load_s       code_load;
        row_entry_s       row_entry;
    } csr_word_u;

    // index hash a, two xor-shift rounds
    function automatic logic [31:0] hash_a(input logic [ROW_W-1:0] row,
                                           input int stack,
                                           input int idx_w);
        logic [31:0] key;
        key = {{(32-ROW_W){1'b0}}, row};
        key = key ^ (key >> (10 - stack));
        key = key ^ (key >> (4 - stack));
        return key & ((32'd1 << idx_w) - 32'd1);
    endfunction

    // index hash b, salted first round
    function automatic logic [31:0] hash_b(input logic [ROW_W-1:0] row,
                                           input int stack,
                                           input int idx_w);
        logic [31:0] key;
        key = {{(32-ROW_W){1'b0}}, row};
        key = (key ^ 32'h9dc5811c) ^ (key >> (5 - stack));
        key = key ^ (key >> (2 - stack));
        return key & ((32'd1 << idx_w) - 32'd1);
    endfunction

endpackage

`default_nettype wire

/* design/filter_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module filter_bank #(
    parameter int FILTER_SIZE = 4096
) (
    input  wire logic                           clk,
    input  wire logic                           wr_en,
    input  wire logic [$clog2(FILTER_SIZE)-1:0] wr_index,
    input  wire logic                           wr_value,
    input  wire logic [$clog2(FILTER_SIZE)-1:0] rd_index,
    output logic                                rd_bit
);

    // one bit per hashed index
    logic bits [FILTER_SIZE];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bits[wr_index] <= wr_value;
        end
    end

    // read returns the value held before a same-edge write
    always_ff @(posedge clk) begin
        rd_bit <= bits[rd_index];
    end

endmodule

`default_nettype wire

/* design/csr_command_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_command_decode (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             csr_valid,
    input  wire row_filter_pkg::csr_word_u        csr_data,
    output row_filter_pkg::filter_mode_e          mode,
    output logic [row_filter_pkg::ROW_W-1:0]      match_mask,
    output logic [row_filter_pkg::ROW_W-1:0]      match_code,
    output logic                                  bit_wr_en,
    output logic                                  bit_wr_value,
    output logic [row_filter_pkg::ROW_W-1:0]      wr_row
);

    import row_filter_pkg::*;

    logic         is_cmd;
    filter_mode_e cmd_mode;
    logic         tags_ok;
    logic         data_strobe;
    logic         bit_mode;

    // command word match
    always_comb begin
        is_cmd   = 1'b1;
        cmd_mode = mode_idle;
        case (csr_data.raw)
            CMD_IDLE: begin
                cmd_mode = mode_idle;
            end
            CMD_INSERT: begin
                cmd_mode = mode_insert;
            end
            CMD_CLEAR: begin
                cmd_mode = mode_clear;
            end
            CMD_LOOKUP: begin
                cmd_mode = mode_lookup;
            end
            CMD_CODE_LOAD: begin
                cmd_mode = mode_code_load;
            end
            CMD_CODE_MATCH: begin
                cmd_mode = mode_code_match;
            end
            default: begin
                is_cmd = 1'b0;
            end
        endcase
    end

    assign tags_ok = (csr_data.code_load.tag_hi == CODE_TAG_HI) &&
                     (csr_data.code_load.tag_lo == CODE_TAG_LO);

    // anything that is not a command is data for the current mode
    assign data_strobe = csr_valid && !is_cmd;
    assign bit_mode    = (mode == mode_insert) || (mode == mode_clear);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode       <= mode_idle;
            match_mask <= '0;
            match_code <= '0;
            bit_wr_en  <= 1'b0;
        end else begin
            bit_wr_en <= data_strobe && bit_mode;
            if (csr_valid && is_cmd) begin
                mode <= cmd_mode;
            end
            // untagged words in code_load mode are dropped
            if (data_strobe && (mode == mode_code_load) && tags_ok) begin
                match_mask <= csr_data.code_load.mask;
                match_code <= csr_data.code_load.code;
            end
        end
    end

    // bit write payload, qualified by bit_wr_en
    always_ff @(posedge clk) begin
        if (data_strobe) begin
            bit_wr_value <= (mode == mode_insert);
            wr_row       <= {csr_data.row_entry.row_hi, csr_data.row_entry.row_lo};
        end
    end

    // a bit write comes only from a data word seen in insert or clear mode
    a_wr_from_bit_mode: assert property (
        @(posedge clk) disable iff (!rst_n)
        bit_wr_en |-> ($past(mode) == mode_insert || $past(mode) == mode_clear)
    );

endmodule

`default_nettype wire

/* design/row_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module row_lookup (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             req_valid,
    input  wire logic [row_filter_pkg::ID_W-1:0]  req_id,
    input  wire logic [row_filter_pkg::ROW_W-1:0] req_row,
    input  wire row_filter_pkg::filter_mode_e     mode,
    input  wire logic [row_filter_pkg::ROW_W-1:0] match_mask,
    input  wire logic [row_filter_pkg::ROW_W-1:0] match_code,
    output logic [row_filter_pkg::ROW_W-1:0]      rd_row_q,
    output logic                                  stage_valid,
    output logic [row_filter_pkg::ID_W-1:0]       stage_id,
    output row_filter_pkg::filter_mode_e          stage_mode,
    output logic                                  stage_code_hit
);

    import row_filter_pkg::*;

    logic masked_eq;
    logic code_hit;

    // masked compare on the incoming row
    assign masked_eq = ((req_row & match_mask) == (match_code & match_mask));
    assign code_hit  = req_valid && (mode == mode_code_match) && masked_eq;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid    <= 1'b0;
            stage_mode     <= mode_idle;
            stage_code_hit <= 1'b0;
        end else begin
            stage_valid    <= req_valid;
            stage_mode     <= mode;
            stage_code_hit <= code_hit;
        end
    end

    // row feeds the bank read hashes at the top
    always_ff @(posedge clk) begin
        rd_row_q <= req_row;
        stage_id <= req_id;
    end

    a_hit_only_in_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        stage_code_hit |-> ($past(mode) == mode_code_match && $past(req_valid))
    );

endmodule

`default_nettype wire

/* design/fault_verdict.sv */
`timescale 1ns/1ps
`default_nettype none

module fault_verdict #(
    parameter int NUM_HASH_STACK = 2
) (
    input  wire logic                            clk,
    input  wire logic                            rst_n,
    input  wire logic                            stage_valid,
    input  wire logic [row_filter_pkg::ID_W-1:0] stage_id,
    input  wire row_filter_pkg::filter_mode_e    stage_mode,
    input  wire logic                            stage_code_hit,
    input  wire logic [2*NUM_HASH_STACK-1:0]     bank_bits,
    output logic                                 rsp_valid,
    output logic [row_filter_pkg::ID_W-1:0]      rsp_id,
    output logic                                 rsp_faulty
);

    import row_filter_pkg::*;

    // one cycle behind stage, lined up with bank_bits
    logic         align_valid;
    logic [ID_W-1:0] align_id;
    filter_mode_e align_mode;
    logic         align_hit;
    logic         verdict;

    always_comb begin
        case (align_mode)
            mode_lookup:     verdict = &bank_bits;
            mode_code_match: verdict = align_hit;
            default:         verdict = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            align_valid <= 1'b0;
            align_mode  <= mode_idle;
            align_hit   <= 1'b0;
            rsp_valid   <= 1'b0;
            rsp_faulty  <= 1'b0;
        end else begin
            align_valid <= stage_valid;
            align_mode  <= stage_mode;
            align_hit   <= stage_code_hit;
            rsp_valid   <= align_valid;
            rsp_faulty  <= align_valid && verdict;
        end
    end

    always_ff @(posedge clk) begin
        align_id <= stage_id;
        rsp_id   <= align_id;
    end

    // flagged response traces back to a request two stages earlier
    a_faulty_has_request: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_faulty |-> (rsp_valid && $past(stage_valid, 2))
    );

endmodule

`default_nettype wire

/* design/row_fault_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module row_fault_filter #(
    parameter int FILTER_SIZE    = 4096,
    parameter int NUM_HASH_STACK = 2
) (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic                             csr_valid,
    input  wire row_filter_pkg::csr_word_u        csr_data,
    input  wire logic                             req_valid,
    input  wire logic [row_filter_pkg::ID_W-1:0]  req_id,
    input  wire logic [row_filter_pkg::ROW_W-1:0] req_row,
    output logic                                  rsp_valid,
    output logic [row_filter_pkg::ID_W-1:0]       rsp_id,
    output logic                                  rsp_faulty
);

    import row_filter_pkg::*;

    localparam int IDX_W = $clog2(FILTER_SIZE);

    filter_mode_e              mode;
    logic [ROW_W-1:0]          match_mask;
    logic [ROW_W-1:0]          match_code;
    logic                      bit_wr_en;
    logic                      bit_wr_value;
    logic [ROW_W-1:0]          wr_row;
    logic [ROW_W-1:0]          rd_row_q;
    logic                      stage_valid;
    logic [ID_W-1:0]           stage_id;
    filter_mode_e              stage_mode;
    logic                      stage_code_hit;
    logic [2*NUM_HASH_STACK-1:0] bank_bits;

    csr_command_decode csr_command_decode_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_valid    (csr_valid),
        .csr_data     (csr_data),
        .mode         (mode),
        .match_mask   (match_mask),
        .match_code   (match_code),
        .bit_wr_en    (bit_wr_en),
        .bit_wr_value (bit_wr_value),
        .wr_row       (wr_row)
    );

    row_lookup row_lookup_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_id         (req_id),
        .req_row        (req_row),
        .mode           (mode),
        .match_mask     (match_mask),
        .match_code     (match_code),
        .rd_row_q       (rd_row_q),
        .stage_valid    (stage_valid),
        .stage_id       (stage_id),
        .stage_mode     (stage_mode),
        .stage_code_hit (stage_code_hit)
    );

    // per stack, bank a at bit 2i and bank b at bit 2i+1
    for (genvar i = 0; i < NUM_HASH_STACK; i++) begin : gen_stack
        logic [31:0] wr_hash_a;
        logic [31:0] wr_hash_b;
        logic [31:0] rd_hash_a;
        logic [31:0] rd_hash_b;

        assign wr_hash_a = hash_a(wr_row, i, IDX_W);
        assign wr_hash_b = hash_b(wr_row, i, IDX_W);
        assign rd_hash_a = hash_a(rd_row_q, i, IDX_W);
        assign rd_hash_b = hash_b(rd_row_q, i, IDX_W);

        filter_bank #(
            .FILTER_SIZE (FILTER_SIZE)
        ) bank_a_inst (
            .clk      (clk),
            .wr_en    (bit_wr_en),
            .wr_index (wr_hash_a[IDX_W-1:0]),
            .wr_value (bit_wr_value),
            .rd_index (rd_hash_a[IDX_W-1:0]),
            .rd_bit   (bank_bits[2*i])
        );

        filter_bank #(
            .FILTER_SIZE (FILTER_SIZE)
        ) bank_b_inst (
            .clk      (clk),
            .wr_en    (bit_wr_en),
            .wr_index (wr_hash_b[IDX_W-1:0]),
            .wr_value (bit_wr_value),
            .rd_index (rd_hash_b[IDX_W-1:0]),
            .rd_bit   (bank_bits[2*i+1])
        );
    end

    fault_verdict #(
        .NUM_HASH_STACK (NUM_HASH_STACK)
    ) fault_verdict_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage_valid    (stage_valid),
        .stage_id       (stage_id),
        .stage_mode     (stage_mode),
        .stage_code_hit (stage_code_hit),
        .bank_bits      (bank_bits),
        .rsp_valid      (rsp_valid),
        .rsp_id         (rsp_id),
        .rsp_faulty     (rsp_faulty)
    );

endmodule

`default_nettype wire

/* testbench/filter_model.svh */
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// bank mirror, bank 2s holds hash_a and bank 2s+1 hash_b of stack s
logic             model_bits [2*NUM_HASH_STACK][FILTER_SIZE];
filter_mode_e     model_mode;
logic [ROW_W-1:0] model_mask;
logic [ROW_W-1:0] model_code;

function automatic logic [IDX_W-1:0] bank_index(input logic [ROW_W-1:0] row, input int bank);
    logic [31:0] h;
    if (bank % 2 == 0) begin
        h = hash_a(row, bank / 2, IDX_W);
    end else begin
        h = hash_b(row, bank / 2, IDX_W);
    end
    return h[IDX_W-1:0];
endfunction

// mode, mask and code follow the word; returns 1 for a bit write
function automatic logic model_accept(input csr_word_u w);
    case (w.raw)
        CMD_IDLE:       model_mode = mode_idle;
        CMD_INSERT:     model_mode = mode_insert;
        CMD_CLEAR:      model_mode = mode_clear;
        CMD_LOOKUP:     model_mode = mode_lookup;
        CMD_CODE_LOAD:  model_mode = mode_code_load;
        CMD_CODE_MATCH: model_mode = mode_code_match;
        default: begin
            if (model_mode == mode_code_load && w.code_load.tag_hi == CODE_TAG_HI &&
                w.code_load.tag_lo == CODE_TAG_LO) begin
                model_mask = w.code_load.mask;
                model_code = w.code_load.code;
            end
            return (model_mode == mode_insert) || (model_mode == mode_clear);
        end
    endcase
    return 1'b0;
endfunction

function automatic void model_write(input logic [ROW_W-1:0] row, input logic value);
    for (int b = 0; b < 2*NUM_HASH_STACK; b++) begin
        model_bits[b][bank_index(row, b)] = value;
    end
endfunction

function automatic logic expected_verdict(input logic [ROW_W-1:0] row);
    logic all_set;
    all_set = 1'b1;
    for (int b = 0; b < 2*NUM_HASH_STACK; b++) begin
        all_set = all_set & model_bits[b][bank_index(row, b)];
    end
    case (model_mode)
        mode_lookup:     return all_set;
        mode_code_match: return ((row ^ model_code) & model_mask) == '0;
        default:         return 1'b0;
    endcase
endfunction

task automatic check_id(input logic [ID_W-1:0] got, input logic [ID_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL t=%0t rsp_id 0x%0h, expected 0x%0h", $time, got, exp);
    end
endtask

task automatic check_faulty(input logic got, input logic exp, input logic [ID_W-1:0] id);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL t=%0t rsp_faulty %b for id 0x%0h, expected %b", $time, got, id, exp);
    end
endtask

task automatic check_valid(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL t=%0t rsp_valid %b, expected %b (%s)", $time, got, exp, what);
    end
endtask

`endif

/* testbench/row_fault_filter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module row_fault_filter_tb;

    import row_filter_pkg::*;

    localparam int FILTER_SIZE     = 4096;
    localparam int NUM_HASH_STACK  = 2;
    localparam int IDX_W           = $clog2(FILTER_SIZE);
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_IDLE_REQ    = 16;
    localparam int NUM_INSERT      = 32;
    localparam int NUM_PROBE       = 32;
    localparam int NUM_CLEAR       = 12;
    localparam int NUM_CODE_REQ    = 40;
    localparam int NUM_B2B         = 32;
    // a control word takes about six cycles, a spaced request two
    localparam int NUM_CSR  = 2*NUM_INSERT + NUM_PROBE + NUM_CLEAR + 16;
    localparam int NUM_REQ  = NUM_IDLE_REQ + 2*NUM_INSERT + 2*NUM_PROBE + 2*NUM_CODE_REQ + NUM_B2B;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6*NUM_CSR + 2*NUM_REQ + 200;

    logic             clk;
    logic             rst_n;
    logic             csr_valid;
    csr_word_u        csr_data;
    logic             req_valid;
    logic [ID_W-1:0]  req_id;
    logic [ROW_W-1:0] req_row;
    logic             rsp_valid;
    logic [ID_W-1:0]  rsp_id;
    logic             rsp_faulty;

    int               error_count;
    int               check_count;
    int               test_count;
    int               errors_at_start;
    int               checks_at_start;
    int               cyc;
    int               seed;
    logic [ID_W-1:0]  next_id;
    logic [ROW_W-1:0] insert_rows [NUM_INSERT];
    logic [ROW_W-1:0] probe_rows [NUM_PROBE];
    logic [ID_W-1:0]  exp_id_q [$];
    logic             exp_faulty_q [$];
    int               exp_due_q [$];

    `include "filter_model.svh"

    row_fault_filter #(
        .FILTER_SIZE    (FILTER_SIZE),
        .NUM_HASH_STACK (NUM_HASH_STACK)
    ) row_fault_filter_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_valid  (csr_valid),
        .csr_data   (csr_data),
        .req_valid  (req_valid),
        .req_id     (req_id),
        .req_row    (req_row),
        .rsp_valid  (rsp_valid),
        .rsp_id     (rsp_id),
        .rsp_faulty (rsp_faulty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // sampled on the falling edge, between register updates
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
                check_valid(rsp_valid, 1'b1, "response due");
                check_id(rsp_id, exp_id_q[0]);
                check_faulty(rsp_faulty, exp_faulty_q[0], exp_id_q[0]);
                void'(exp_id_q.pop_front());
                void'(exp_faulty_q.pop_front());
                void'(exp_due_q.pop_front());
            end else begin
                check_valid(rsp_valid, 1'b0, "nothing in flight");
                check_faulty(rsp_faulty, 1'b0, rsp_id);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with %0d responses owed",
                 WATCHDOG_CYCLES, exp_due_q.size());
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [ROW_W-1:0] random_row();
        logic [31:0] r;
        r = $random(seed);
        return r[ROW_W-1:0];
    endfunction

    task automatic send_csr(input csr_word_u w);
        logic wr_pending;
        logic wr_value;
        @(negedge clk);
        csr_valid = 1'b1;
        csr_data  = w;
        @(posedge clk);
        wr_value   = (model_mode == mode_insert);
        wr_pending = model_accept(w);
        @(negedge clk);
        csr_valid = 1'b0;
        // bank bit lands one edge after the strobe
        @(posedge clk);
        if (wr_pending) begin
            model_write({w.row_entry.row_hi, w.row_entry.row_lo}, wr_value);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic send_command(input logic [CSR_W-1:0] raw);
        csr_word_u w;
        w.raw = raw;
        send_csr(w);
    endtask

    task automatic send_row(input logic [ROW_W-1:0] row);
        csr_word_u w;
        w.raw              = '0;
        w.row_entry.row_hi = row[ROW_W-1:2];
        w.row_entry.row_lo = row[1:0];
        send_csr(w);
    endtask

    task automatic send_request(input logic [ROW_W-1:0] row, input logic exp_faulty);
        @(negedge clk);
        req_valid = 1'b1;
        req_id    = next_id;
        req_row   = row;
        exp_id_q.push_back(next_id);
        exp_faulty_q.push_back(exp_faulty);
        exp_due_q.push_back(cyc + 3);
        next_id = next_id + ID_W'(1);
    endtask

    task automatic end_requests();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
        checks_at_start = check_count;
    endtask

    task automatic end_test(input string name);
        while (exp_due_q.size() > 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        test_count++;
        $display("test %0d %-16s checks %0d errors %0d", test_count, name,
                 check_count - checks_at_start, error_count - errors_at_start);
    endtask

    task automatic code_requests(input logic [ROW_W-1:0] mask, input logic [ROW_W-1:0] code);
        logic [ROW_W-1:0] row;
        for (int i = 0; i < NUM_CODE_REQ; i++) begin
            row = (i % 2 == 0) ? ((code & mask) | (random_row() & ~mask)) : random_row();
            send_request(row, expected_verdict(row));
            end_requests();
        end
    endtask

    task automatic run_tests();
        csr_word_u        w;
        logic [ROW_W-1:0] code_mask;
        logic [ROW_W-1:0] code_val;

        begin_test();
        for (int i = 0; i < NUM_IDLE_REQ; i++) begin
            send_request(random_row(), 1'b0);
            end_requests();
        end
        end_test("reset_idle");

        // every row looked up later starts from known zero bits
        begin_test();
        send_command(CMD_CLEAR);
        for (int i = 0; i < NUM_INSERT; i++) send_row(insert_rows[i]);
        for (int i = 0; i < NUM_PROBE; i++) send_row(probe_rows[i]);
        send_command(CMD_INSERT);
        for (int i = 0; i < NUM_INSERT; i++) send_row(insert_rows[i]);
        send_command(CMD_LOOKUP);
        for (int i = 0; i < NUM_INSERT; i++) begin
            send_request(insert_rows[i], 1'b1);
            end_requests();
        end
        end_test("insert_lookup");

        begin_test();
        for (int i = 0; i < NUM_PROBE; i++) begin
            send_request(probe_rows[i], expected_verdict(probe_rows[i]));
            end_requests();
        end
        end_test("not_inserted");

        begin_test();
        send_command(CMD_CLEAR);
        for (int i = 0; i < NUM_CLEAR; i++) send_row(insert_rows[i]);
        send_command(CMD_LOOKUP);
        for (int i = 0; i < NUM_INSERT; i++) begin
            send_request(insert_rows[i],
                         (i < NUM_CLEAR) ? 1'b0 : expected_verdict(insert_rows[i]));
            end_requests();
        end
        end_test("clear");

        begin_test();
        code_mask = 20'hF0F3C;
        code_val  = random_row();
        send_command(CMD_CODE_LOAD);
        w.code_load = '{tag_hi: CODE_TAG_HI, mask: code_mask, code: code_val, tag_lo: CODE_TAG_LO};
        send_csr(w);
        send_command(CMD_CODE_MATCH);
        code_requests(code_mask, code_val);
        // wrong upper tag, old mask and code stay
        send_command(CMD_CODE_LOAD);
        w.code_load = '{tag_hi: CODE_TAG_HI ^ 12'h001, mask: ~code_mask, code: ~code_val,
                        tag_lo: CODE_TAG_LO};
        send_csr(w);
        send_command(CMD_CODE_MATCH);
        code_requests(code_mask, code_val);
        end_test("code_match");

        begin_test();
        send_command(CMD_LOOKUP);
        for (int i = 0; i < NUM_B2B; i++) begin
            if (i % 2 == 0) begin
                send_request(insert_rows[i], expected_verdict(insert_rows[i]));
            end else begin
                send_request(probe_rows[i], expected_verdict(probe_rows[i]));
            end
        end
        end_requests();
        end_test("back_to_back");
    endtask

    initial begin
        seed       = 32'h2b70de2d;
        next_id    = '0;
        rst_n      = 1'b0;
        csr_valid  = 1'b0;
        csr_data   = '0;
        req_valid  = 1'b0;
        req_id     = '0;
        req_row    = '0;
        model_mode = mode_idle;
        model_mask = '0;
        model_code = '0;
        for (int i = 0; i < NUM_INSERT; i++) insert_rows[i] = random_row();
        for (int i = 0; i < NUM_PROBE; i++) probe_rows[i] = random_row();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_tests();
        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* row_fault_filter.f */
+incdir+testbench
design/row_filter_pkg.sv
design/filter_bank.sv
design/csr_command_decode.sv
design/row_lookup.sv
design/fault_verdict.sv
design/row_fault_filter.sv
testbench/row_fault_filter_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f row_fault_filter.f --top-module row_fault_filter_tb \
    -o row_fault_filter_sim > build.log 2>&1 \
    && ./obj_dir/row_fault_filter_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "pass line found" \
    || { echo "pass line missing from sim.log"; exit 1; }
